/* design/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_idx_t;

    // major opcodes of the supported subset
    localparam logic [6:0] op_lui     = 7'b0110111;
    localparam logic [6:0] op_auipc   = 7'b0010111;
    localparam logic [6:0] op_jal     = 7'b1101111;
    localparam logic [6:0] op_jalr    = 7'b1100111;
    localparam logic [6:0] op_branch  = 7'b1100011;
    localparam logic [6:0] op_load    = 7'b0000011;
    localparam logic [6:0] op_store   = 7'b0100011;
    localparam logic [6:0] op_alu_imm = 7'b0010011;
    localparam logic [6:0] op_alu_reg = 7'b0110011;

    typedef enum logic [3:0]
    {
        kind_alu,
        kind_lui,
        kind_auipc,
        kind_jal,
        kind_jalr,
        kind_branch,
        kind_load,
        kind_store,
        kind_invalid
    } inst_kind_e;

    // compare ops return 0 or 1 in bit 0
    typedef enum logic [3:0]
    {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_eq,
        alu_ne,
        alu_ge,
        alu_geu
    } alu_op_e;

    typedef struct packed
    {
        inst_kind_e      kind;
        alu_op_e         alu_op;
        logic            use_imm;
        reg_idx_t        rd;
        reg_idx_t        rs1;
        reg_idx_t        rs2;
        logic [xlen-1:0] imm;
    } decoded_inst_t;

    typedef struct packed
    {
        logic            write_en;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

/* design/cpu_decode.sv */
`default_nettype none

module cpu_decode
(
    input  logic [31:0]            i_inst,
    output cpu_pkg::decoded_inst_t o_dec
);

logic [6:0]       w_opcode;
logic [2:0]       w_funct3;
logic [6:0]       w_funct7;
logic             w_is_reg;
logic             w_f7_zero;
logic             w_f7_alt;
logic             w_reg_ok;
logic             w_imm_ok;
logic             w_branch_ok;
cpu_pkg::alu_op_e w_alu_op;
cpu_pkg::alu_op_e w_branch_op;
logic [31:0]      w_imm_i;
logic [31:0]      w_imm_s;
logic [31:0]      w_imm_b;
logic [31:0]      w_imm_u;
logic [31:0]      w_imm_j;

assign w_opcode  = i_inst[6:0];
assign w_funct3  = i_inst[14:12];
assign w_funct7  = i_inst[31:25];
assign w_is_reg  = (w_opcode == cpu_pkg::op_alu_reg);
assign w_f7_zero = (w_funct7 == 7'b0000000);
assign w_f7_alt  = (w_funct7 == 7'b0100000);

// funct7 may only be the alternate form for sub, srl/sra
assign w_reg_ok = w_f7_zero || (w_f7_alt && (w_funct3 == 3'b000 || w_funct3 == 3'b101));
assign w_imm_ok = (w_funct3 == 3'b001) ? w_f7_zero :
                  ((w_funct3 != 3'b101) || w_f7_zero || w_f7_alt);

assign w_imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
assign w_imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
assign w_imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
assign w_imm_u = {i_inst[31:12], 12'b0};
assign w_imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

always_comb
begin
    case (w_funct3)
        3'b000:  w_alu_op = (w_is_reg && w_funct7[5]) ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
        3'b001:  w_alu_op = cpu_pkg::alu_sll;
        3'b010:  w_alu_op = cpu_pkg::alu_slt;
        3'b011:  w_alu_op = cpu_pkg::alu_sltu;
        3'b100:  w_alu_op = cpu_pkg::alu_xor;
        3'b101:  w_alu_op = w_funct7[5] ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
        3'b110:  w_alu_op = cpu_pkg::alu_or;
        default: w_alu_op = cpu_pkg::alu_and;
    endcase
end

always_comb
begin
    w_branch_ok = 1'b1;
    case (w_funct3)
        3'b000:  w_branch_op = cpu_pkg::alu_eq;
        3'b001:  w_branch_op = cpu_pkg::alu_ne;
        3'b100:  w_branch_op = cpu_pkg::alu_slt;
        3'b101:  w_branch_op = cpu_pkg::alu_ge;
        3'b110:  w_branch_op = cpu_pkg::alu_sltu;
        3'b111:  w_branch_op = cpu_pkg::alu_geu;
        default:
        begin
            w_branch_op = cpu_pkg::alu_eq;
            w_branch_ok = 1'b0;
        end
    endcase
end

always_comb
begin
    o_dec        = '0;
    o_dec.kind   = cpu_pkg::kind_invalid;
    o_dec.alu_op = cpu_pkg::alu_add;
    o_dec.rd     = i_inst[11:7];
    o_dec.rs1    = i_inst[19:15];
    o_dec.rs2    = i_inst[24:20];
    o_dec.imm    = w_imm_i;
    case (w_opcode)
        cpu_pkg::op_lui:
        begin
            o_dec.kind = cpu_pkg::kind_lui;
            o_dec.imm  = w_imm_u;
        end
        cpu_pkg::op_auipc:
        begin
            o_dec.kind = cpu_pkg::kind_auipc;
            o_dec.imm  = w_imm_u;
        end
        cpu_pkg::op_jal:
        begin
            o_dec.kind = cpu_pkg::kind_jal;
            o_dec.imm  = w_imm_j;
        end
        cpu_pkg::op_jalr:
        begin
            if (w_funct3 == 3'b000)
                o_dec.kind = cpu_pkg::kind_jalr;
            o_dec.use_imm = 1'b1;
        end
        cpu_pkg::op_branch:
        begin
            if (w_branch_ok)
                o_dec.kind = cpu_pkg::kind_branch;
            o_dec.alu_op = w_branch_op;
            o_dec.imm    = w_imm_b;
        end
        // only word accesses
        cpu_pkg::op_load:
        begin
            if (w_funct3 == 3'b010)
                o_dec.kind = cpu_pkg::kind_load;
            o_dec.use_imm = 1'b1;
        end
        cpu_pkg::op_store:
        begin
            if (w_funct3 == 3'b010)
                o_dec.kind = cpu_pkg::kind_store;
            o_dec.use_imm = 1'b1;
            o_dec.imm     = w_imm_s;
        end
        cpu_pkg::op_alu_imm:
        begin
            if (w_imm_ok)
                o_dec.kind = cpu_pkg::kind_alu;
            o_dec.alu_op  = w_alu_op;
            o_dec.use_imm = 1'b1;
        end
        cpu_pkg::op_alu_reg:
        begin
            if (w_reg_ok)
                o_dec.kind = cpu_pkg::kind_alu;
            o_dec.alu_op = w_alu_op;
        end
        default: o_dec.kind = cpu_pkg::kind_invalid;
    endcase
end

endmodule

`default_nettype wire

/* design/cpu_regfile.sv */
`default_nettype none

module cpu_regfile
(
    input  logic                     i_clk,

    input  cpu_pkg::reg_idx_t        i_rs1,
    input  cpu_pkg::reg_idx_t        i_rs2,
    output logic [cpu_pkg::xlen-1:0] o_rs1_data,
    output logic [cpu_pkg::xlen-1:0] o_rs2_data,

    input  logic                     i_we,
    input  cpu_pkg::reg_idx_t        i_rd,
    input  logic [cpu_pkg::xlen-1:0] i_rd_data
);

// x0 has no storage
logic [cpu_pkg::xlen-1:0] r_regs [1:31];

assign o_rs1_data = (i_rs1 == '0) ? '0 : r_regs[i_rs1];
assign o_rs2_data = (i_rs2 == '0) ? '0 : r_regs[i_rs2];

always_ff @(posedge i_clk)
begin
    if (i_we && i_rd != '0)
        r_regs[i_rd] <= i_rd_data;
end

endmodule

`default_nettype wire

/* design/cpu_alu.sv */
`default_nettype none

module cpu_alu
(
    input  cpu_pkg::alu_op_e         i_op,
    input  logic [cpu_pkg::xlen-1:0] i_a,
    input  logic [cpu_pkg::xlen-1:0] i_b,
    output logic [cpu_pkg::xlen-1:0] o_result
);

logic [4:0] w_shamt;
logic       w_lt;
logic       w_ltu;
logic       w_eq;

assign w_shamt = i_b[4:0];
assign w_lt    = ($signed(i_a) < $signed(i_b));
assign w_ltu   = (i_a < i_b);
assign w_eq    = (i_a == i_b);

always_comb
begin
    o_result = '0;
    case (i_op)
        cpu_pkg::alu_add:  o_result = i_a + i_b;
        cpu_pkg::alu_sub:  o_result = i_a - i_b;
        cpu_pkg::alu_sll:  o_result = i_a << w_shamt;
        cpu_pkg::alu_xor:  o_result = i_a ^ i_b;
        cpu_pkg::alu_srl:  o_result = i_a >> w_shamt;
        cpu_pkg::alu_sra:  o_result = $signed(i_a) >>> w_shamt;
        cpu_pkg::alu_or:   o_result = i_a | i_b;
        cpu_pkg::alu_and:  o_result = i_a & i_b;
        // compares set bit 0 only
        cpu_pkg::alu_slt:  o_result[0] = w_lt;
        cpu_pkg::alu_sltu: o_result[0] = w_ltu;
        cpu_pkg::alu_eq:   o_result[0] = w_eq;
        cpu_pkg::alu_ne:   o_result[0] = !w_eq;
        cpu_pkg::alu_ge:   o_result[0] = !w_lt;
        cpu_pkg::alu_geu:  o_result[0] = !w_ltu;
        default:           o_result = '0;
    endcase
end

endmodule

`default_nettype wire

/* design/cpu_control.sv */
`default_nettype none

module cpu_control
#(
    parameter logic [cpu_pkg::xlen-1:0] reset_pc = '0
)
(
    input  logic                     i_clk,
    input  logic                     i_rst,

    output logic [31:0]              o_inst,
    input  cpu_pkg::decoded_inst_t   i_dec,

    input  logic [cpu_pkg::xlen-1:0] i_rs1_data,
    input  logic [cpu_pkg::xlen-1:0] i_rs2_data,

    output logic                     o_rd_we,
    output cpu_pkg::reg_idx_t        o_rd_idx,
    output logic [cpu_pkg::xlen-1:0] o_rd_data,

    output logic [cpu_pkg::xlen-1:0] o_alu_b,
    output cpu_pkg::alu_op_e         o_alu_op,
    input  logic [cpu_pkg::xlen-1:0] i_alu_result,

    output cpu_pkg::mem_req_t        o_mem_req,
    input  logic [cpu_pkg::xlen-1:0] i_mem_rdata,
    output logic                     o_halted
);

typedef enum logic [2:0]
{
    st_fetch,
    st_wait,
    st_capture,
    st_execute,
    st_load_wait,
    st_writeback,
    st_halt
} state_e;

state_e                   r_state;
logic [cpu_pkg::xlen-1:0] r_pc;
logic [31:0]              r_inst;
logic                     r_mem_we;
logic [cpu_pkg::xlen-1:0] r_mem_addr;
logic [cpu_pkg::xlen-1:0] r_mem_wdata;

logic [cpu_pkg::xlen-1:0] w_pc_plus4;
logic [cpu_pkg::xlen-1:0] w_pc_imm;
logic [cpu_pkg::xlen-1:0] w_jalr_sum;
logic [cpu_pkg::xlen-1:0] w_next_pc;
logic                     w_is_mem;

assign o_inst   = r_inst;
assign o_alu_op = i_dec.alu_op;
assign o_alu_b  = i_dec.use_imm ? i_dec.imm : i_rs2_data;
assign o_rd_idx = i_dec.rd;
assign o_halted = (r_state == st_halt);

assign o_mem_req.write_en = r_mem_we;
assign o_mem_req.addr     = r_mem_addr;
assign o_mem_req.wdata    = r_mem_wdata;

assign w_pc_plus4 = r_pc + 4;
assign w_pc_imm   = r_pc + i_dec.imm;
assign w_jalr_sum = i_rs1_data + i_dec.imm;
assign w_is_mem   = (i_dec.kind == cpu_pkg::kind_load) || (i_dec.kind == cpu_pkg::kind_store);

// branch taken flag is bit 0 of the compare
always_comb
begin
    case (i_dec.kind)
        cpu_pkg::kind_jal:    w_next_pc = w_pc_imm;
        cpu_pkg::kind_jalr:   w_next_pc = {w_jalr_sum[cpu_pkg::xlen-1:1], 1'b0};
        cpu_pkg::kind_branch: w_next_pc = i_alu_result[0] ? w_pc_imm : w_pc_plus4;
        default:              w_next_pc = w_pc_plus4;
    endcase
end

always_comb
begin
    o_rd_we   = 1'b0;
    o_rd_data = i_alu_result;
    if (r_state == st_writeback)
    begin
        o_rd_we   = 1'b1;
        o_rd_data = i_mem_rdata;
    end
    else if (r_state == st_execute)
    begin
        case (i_dec.kind)
            cpu_pkg::kind_alu:
                o_rd_we = 1'b1;
            cpu_pkg::kind_lui:
            begin
                o_rd_we   = 1'b1;
                o_rd_data = i_dec.imm;
            end
            cpu_pkg::kind_auipc:
            begin
                o_rd_we   = 1'b1;
                o_rd_data = w_pc_imm;
            end
            cpu_pkg::kind_jal, cpu_pkg::kind_jalr:
            begin
                o_rd_we   = 1'b1;
                o_rd_data = w_pc_plus4;
            end
            default:
                o_rd_we = 1'b0;
        endcase
    end
end

always_ff @(posedge i_clk)
begin
    if (i_rst)
    begin
        r_state  <= st_fetch;
        r_pc     <= reset_pc;
        r_mem_we <= 1'b0;
    end
    else
    begin
        case (r_state)
            st_fetch:
            begin
                // a store from the last execute is written on this edge
                r_mem_we <= 1'b0;
                r_state  <= st_wait;
            end
            st_wait:    r_state <= st_capture;
            st_capture: r_state <= st_execute;
            st_execute:
            begin
                if (i_dec.kind == cpu_pkg::kind_invalid)
                    r_state <= st_halt;
                else
                begin
                    r_pc     <= w_next_pc;
                    r_mem_we <= (i_dec.kind == cpu_pkg::kind_store);
                    if (i_dec.kind == cpu_pkg::kind_load)
                        r_state <= st_load_wait;
                    else
                        r_state <= st_fetch;
                end
            end
            st_load_wait: r_state <= st_writeback;
            st_writeback: r_state <= st_fetch;
            default:      r_state <= st_halt;
        endcase
    end
end

// instruction buffer and request payload
always_ff @(posedge i_clk)
begin
    if (r_state == st_capture)
        r_inst <= i_mem_rdata;
    if (r_state == st_fetch)
        r_mem_addr <= r_pc;
    else if (r_state == st_execute && w_is_mem)
    begin
        r_mem_addr  <= i_alu_result;
        r_mem_wdata <= i_rs2_data;
    end
end

endmodule

`default_nettype wire

/* design/cpu_top.sv */
`default_nettype none

module cpu_top
#(
    parameter logic [cpu_pkg::xlen-1:0] reset_pc = '0
)
(
    input  logic                     i_clk,
    input  logic                     i_rst,

    output cpu_pkg::mem_req_t        o_mem_req,
    input  logic [cpu_pkg::xlen-1:0] i_mem_rdata,

    output logic                     o_halted
);

logic [31:0]              w_inst;
cpu_pkg::decoded_inst_t   w_dec;
logic [cpu_pkg::xlen-1:0] w_rs1_data;
logic [cpu_pkg::xlen-1:0] w_rs2_data;
logic                     w_rd_we;
cpu_pkg::reg_idx_t        w_rd_idx;
logic [cpu_pkg::xlen-1:0] w_rd_data;
logic [cpu_pkg::xlen-1:0] w_alu_b;
cpu_pkg::alu_op_e         w_alu_op;
logic [cpu_pkg::xlen-1:0] w_alu_result;

cpu_control #(.reset_pc(reset_pc)) u_control
(
    .i_clk(i_clk),
    .i_rst(i_rst),
    .o_inst(w_inst),
    .i_dec(w_dec),
    .i_rs1_data(w_rs1_data),
    .i_rs2_data(w_rs2_data),
    .o_rd_we(w_rd_we),
    .o_rd_idx(w_rd_idx),
    .o_rd_data(w_rd_data),
    .o_alu_b(w_alu_b),
    .o_alu_op(w_alu_op),
    .i_alu_result(w_alu_result),
    .o_mem_req(o_mem_req),
    .i_mem_rdata(i_mem_rdata),
    .o_halted(o_halted)
);

cpu_decode u_decode
(
    .i_inst(w_inst),
    .o_dec(w_dec)
);

cpu_regfile u_regfile
(
    .i_clk(i_clk),
    .i_rs1(w_dec.rs1),
    .i_rs2(w_dec.rs2),
    .o_rs1_data(w_rs1_data),
    .o_rs2_data(w_rs2_data),
    .i_we(w_rd_we),
    .i_rd(w_rd_idx),
    .i_rd_data(w_rd_data)
);

cpu_alu u_alu
(
    .i_op(w_alu_op),
    .i_a(w_rs1_data),
    .i_b(w_alu_b),
    .o_result(w_alu_result)
);

endmodule

`default_nettype wire

/* dv/cpu_assert.sv */
`default_nettype none

module cpu_assert
(
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_write_en,
    input  logic i_halted
);

timeunit 1ns;
timeprecision 1ps;

// a store request lasts one cycle
a_single_write: assert property (@(posedge i_clk) disable iff (i_rst)
    i_write_en |=> !i_write_en)
    else $error("memory write enable high on two consecutive cycles");

// only reset leaves halt
a_halt_sticky: assert property (@(posedge i_clk) disable iff (i_rst)
    i_halted |=> i_halted)
    else $error("halted output dropped without a reset");

a_no_write_halted: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_write_en && i_halted))
    else $error("memory write requested while the core is halted");

endmodule

`default_nettype wire

/* dv/cpu_tb.sv */
`default_nettype none

module cpu_tb;

timeunit 1ns;
timeprecision 1ps;

localparam logic [31:0] start_pc     = 32'h0000_0080;
localparam logic [31:0] data_base    = 32'h0000_0200;
localparam logic [31:0] result_base  = 32'h0000_0300;
localparam int          mem_words    = 256;
localparam int          halt_timeout = 2000;

logic              clk;
logic              rst;
cpu_pkg::mem_req_t mem_req;
logic [31:0]       mem_rdata;
logic              halted;

logic [31:0]       mem [0:mem_words-1];
int                n_writes;
cpu_pkg::mem_req_t port_req;
logic [31:0]       port_word;

logic [31:0]       lfsr_state;
logic [31:0]       exp_addr [$];
logic [31:0]       exp_data [$];
int                prog_idx;
int                n_errors;
int                n_tests;
int                n_failed_tests;
logic              check_req;
logic              check_done;
string             test_name;

cpu_top #(.reset_pc(start_pc)) uut
(
    .i_clk(clk),
    .i_rst(rst),
    .o_mem_req(mem_req),
    .i_mem_rdata(mem_rdata),
    .o_halted(halted)
);

bind cpu_control cpu_assert u_assert
(
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_write_en(r_mem_we),
    .i_halted(o_halted)
);

initial
begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

// memory model with one-cycle read latency and writes on the edge
always
begin
    @(posedge clk);
    port_req  = mem_req;
    port_word = mem[port_req.addr[9:2]];
    if (port_req.write_en === 1'b1)
    begin
        mem[port_req.addr[9:2]] = port_req.wdata;
        n_writes++;
    end
    #1;
    mem_rdata = port_word;
end

function automatic logic [31:0] fill_word(int idx);
    logic [31:0] a;
    a = idx << 2;
    return {~a[15:0], a[15:0]};
endfunction

function automatic logic [31:0] word_at(logic [31:0] addr);
    return mem[addr[9:2]];
endfunction

// galois lfsr stepped once per bit
function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
        lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

function automatic logic [31:0] r_format(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, cpu_pkg::op_alu_reg};
endfunction

function automatic logic [31:0] i_format(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] s_format(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpu_pkg::op_store};
endfunction

function automatic logic [31:0] b_format(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], cpu_pkg::op_branch};
endfunction

function automatic logic [31:0] u_format(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] j_format(logic [20:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, cpu_pkg::op_jal};
endfunction

function automatic logic [31:0] load_word(logic [4:0] rd, logic [11:0] off);
    return i_format(off, 5'd0, 3'b010, rd, cpu_pkg::op_load);
endfunction

function automatic logic [31:0] store_word(logic [4:0] rs2, logic [11:0] off);
    return s_format(off, rs2, 5'd0);
endfunction

function automatic logic [2:0] funct3_of(cpu_pkg::alu_op_e op);
    case (op)
        cpu_pkg::alu_sll:                  return 3'd1;
        cpu_pkg::alu_slt:                  return 3'd2;
        cpu_pkg::alu_sltu:                 return 3'd3;
        cpu_pkg::alu_xor:                  return 3'd4;
        cpu_pkg::alu_srl, cpu_pkg::alu_sra: return 3'd5;
        cpu_pkg::alu_or:                   return 3'd6;
        cpu_pkg::alu_and:                  return 3'd7;
        default:                           return 3'd0;
    endcase
endfunction

function automatic logic [6:0] funct7_of(cpu_pkg::alu_op_e op);
    return (op == cpu_pkg::alu_sub || op == cpu_pkg::alu_sra) ? 7'h20 : 7'h00;
endfunction

// expected result from the rv32i rules
function automatic logic [31:0] ref_alu(cpu_pkg::alu_op_e op, logic [31:0] a, logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
        cpu_pkg::alu_add:  return a + b;
        cpu_pkg::alu_sub:  return a - b;
        cpu_pkg::alu_sll:  return a << sh;
        cpu_pkg::alu_srl:  return a >> sh;
        cpu_pkg::alu_sra:  return 32'($signed(a) >>> sh);
        cpu_pkg::alu_xor:  return a ^ b;
        cpu_pkg::alu_or:   return a | b;
        cpu_pkg::alu_and:  return a & b;
        cpu_pkg::alu_slt:  return {31'b0, $signed(a) < $signed(b)};
        cpu_pkg::alu_sltu: return {31'b0, a < b};
        cpu_pkg::alu_eq:   return {31'b0, a == b};
        cpu_pkg::alu_ne:   return {31'b0, a != b};
        cpu_pkg::alu_ge:   return {31'b0, $signed(a) >= $signed(b)};
        default:           return {31'b0, a >= b};
    endcase
endfunction

task automatic place(input logic [31:0] word);
    mem[prog_idx] = word;
    prog_idx++;
endtask

task automatic poke(input logic [31:0] addr, input logic [31:0] value);
    mem[addr[9:2]] = value;
endtask

task automatic expect_word(input logic [31:0] addr, input logic [31:0] value);
    exp_addr.push_back(addr);
    exp_data.push_back(value);
endtask

task automatic begin_test(input string name);
    @(posedge clk);
    #1;
    rst = 1'b1;
    test_name = name;
    for (int i = 0; i < mem_words; i++)
        mem[i] = fill_word(i);
    exp_addr.delete();
    exp_data.delete();
    prog_idx = int'(start_pc[9:2]);
endtask

task automatic finish_test(input int post_halt_cycles);
    int   cycles;
    int   errors_before;
    int   writes_at_halt;
    logic done;
    errors_before = n_errors;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    done = 1'b0;
    cycles = 0;
    while (!done && cycles < halt_timeout)
    begin
        @(negedge clk);
        cycles++;
        done = halted;
    end
    if (!done)
    begin
        $display("%s: core did not halt within %0d cycles", test_name, halt_timeout);
        n_errors++;
    end
    else
    begin
        writes_at_halt = n_writes;
        repeat (post_halt_cycles) @(negedge clk);
        assert (halted && n_writes == writes_at_halt)
        else
        begin
            $display("%s: core left halt or wrote memory after halting", test_name);
            n_errors++;
        end
        check_req = 1'b1;
        cycles = 0;
        while (!check_done && cycles < 10)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!check_done)
        begin
            $display("%s: memory compare did not complete", test_name);
            n_errors++;
        end
        check_req  = 1'b0;
        check_done = 1'b0;
    end
    n_tests++;
    if (n_errors == errors_before)
        $display("%s: pass", test_name);
    else
    begin
        n_failed_tests++;
        $display("%s: FAIL, %0d errors", test_name, n_errors - errors_before);
    end
endtask

// compares memory against the expected words once the core halts
always @(posedge clk)
begin
    if (check_req && !check_done)
    begin
        foreach (exp_addr[i])
        begin
            assert (word_at(exp_addr[i]) === exp_data[i])
            else
            begin
                $display("[ERROR] %s: mem[%08h] expected %08h got %08h", test_name,
                         exp_addr[i], exp_data[i], word_at(exp_addr[i]));
                n_errors++;
            end
        end
        check_done = 1'b1;
    end
end

task automatic test_reg_alu();
    cpu_pkg::alu_op_e ops [10] = '{cpu_pkg::alu_add, cpu_pkg::alu_sub, cpu_pkg::alu_sll,
                                   cpu_pkg::alu_slt, cpu_pkg::alu_sltu, cpu_pkg::alu_xor,
                                   cpu_pkg::alu_srl, cpu_pkg::alu_sra, cpu_pkg::alu_or,
                                   cpu_pkg::alu_and};
    logic [31:0] a;
    logic [31:0] b;
    begin_test("reg-reg alu");
    a = take_bits(32);
    b = take_bits(32);
    poke(data_base, a);
    poke(data_base + 4, b);
    place(load_word(5'd1, data_base[11:0]));
    place(load_word(5'd2, data_base[11:0] + 12'd4));
    for (int k = 0; k < 10; k++)
    begin
        place(r_format(funct7_of(ops[k]), 5'd2, 5'd1, funct3_of(ops[k]), 5'(k + 3)));
        place(store_word(5'(k + 3), 12'(result_base + 4 * k)));
        expect_word(result_base + 4 * k, ref_alu(ops[k], a, b));
    end
    place(32'h0);
    finish_test(0);
endtask

task automatic test_imm_alu();
    cpu_pkg::alu_op_e ops [9] = '{cpu_pkg::alu_add, cpu_pkg::alu_slt, cpu_pkg::alu_sltu,
                                  cpu_pkg::alu_xor, cpu_pkg::alu_or, cpu_pkg::alu_and,
                                  cpu_pkg::alu_sll, cpu_pkg::alu_srl, cpu_pkg::alu_sra};
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] imm;
    begin_test("reg-imm alu");
    a = take_bits(32);
    poke(data_base, a);
    place(load_word(5'd1, data_base[11:0]));
    for (int k = 0; k < 9; k++)
    begin
        if (k < 6)
        begin
            imm = 12'(take_bits(12));
            b   = {{20{imm[11]}}, imm};
        end
        else
        begin
            b   = take_bits(5);
            imm = {funct7_of(ops[k]), b[4:0]};
        end
        place(i_format(imm, 5'd1, funct3_of(ops[k]), 5'(k + 3), cpu_pkg::op_alu_imm));
        place(store_word(5'(k + 3), 12'(result_base + 4 * k)));
        expect_word(result_base + 4 * k, ref_alu(ops[k], a, b));
    end
    place(32'h0);
    finish_test(0);
endtask

task automatic test_upper();
    logic [19:0] up_lui;
    logic [19:0] up_auipc;
    begin_test("lui and auipc");
    up_lui   = 20'(take_bits(20));
    up_auipc = 20'(take_bits(20));
    place(u_format(up_lui, 5'd1, cpu_pkg::op_lui));
    place(store_word(5'd1, result_base[11:0]));
    // auipc sits at start_pc + 8
    place(u_format(up_auipc, 5'd2, cpu_pkg::op_auipc));
    place(store_word(5'd2, result_base[11:0] + 12'd4));
    place(32'h0);
    expect_word(result_base, {up_lui, 12'h0});
    expect_word(result_base + 4, start_pc + 8 + {up_auipc, 12'h0});
    finish_test(0);
endtask

task automatic test_branches();
    cpu_pkg::alu_op_e ops [6] = '{cpu_pkg::alu_eq, cpu_pkg::alu_ne, cpu_pkg::alu_slt,
                                  cpu_pkg::alu_ge, cpu_pkg::alu_sltu, cpu_pkg::alu_geu};
    logic [2:0]  f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] cmp;
    begin_test("branches");
    for (int k = 0; k < 6; k++)
    begin
        a = take_bits(32);
        // equal operands for beq and bge
        b = (k == 0 || k == 3) ? a : take_bits(32);
        poke(data_base + 8 * k, a);
        poke(data_base + 8 * k + 4, b);
        place(load_word(5'd1, 12'(data_base + 8 * k)));
        place(load_word(5'd2, 12'(data_base + 8 * k + 4)));
        place(i_format(12'd1, 5'd0, 3'd0, 5'd3, cpu_pkg::op_alu_imm));
        place(b_format(13'd8, 5'd2, 5'd1, f3[k]));
        place(i_format(12'd2, 5'd0, 3'd0, 5'd3, cpu_pkg::op_alu_imm));
        place(store_word(5'd3, 12'(result_base + 4 * k)));
        cmp = ref_alu(ops[k], a, b);
        expect_word(result_base + 4 * k, cmp[0] ? 32'd1 : 32'd2);
    end
    place(32'h0);
    finish_test(0);
endtask

task automatic test_jumps();
    logic [31:0] target;
    begin_test("jal and jalr");
    target = start_pc + 24;
    place(i_format(12'd7, 5'd0, 3'd0, 5'd5, cpu_pkg::op_alu_imm));
    place(j_format(21'd8, 5'd1));
    place(i_format(12'd9, 5'd0, 3'd0, 5'd5, cpu_pkg::op_alu_imm));
    // base is target + 5, so offset -4 leaves the low bit set
    place(i_format(12'(target + 5), 5'd0, 3'd0, 5'd6, cpu_pkg::op_alu_imm));
    place(i_format(12'hffc, 5'd6, 3'd0, 5'd2, cpu_pkg::op_jalr));
    place(i_format(12'd11, 5'd0, 3'd0, 5'd5, cpu_pkg::op_alu_imm));
    // auipc at the target records the pc with bit 0 cleared
    place(u_format(20'h0, 5'd7, cpu_pkg::op_auipc));
    place(store_word(5'd1, result_base[11:0]));
    place(store_word(5'd2, result_base[11:0] + 12'd4));
    place(store_word(5'd5, result_base[11:0] + 12'd8));
    place(store_word(5'd7, result_base[11:0] + 12'd12));
    place(32'h0);
    expect_word(result_base, start_pc + 8);
    expect_word(result_base + 4, start_pc + 20);
    expect_word(result_base + 8, 32'd7);
    expect_word(result_base + 12, target);
    finish_test(0);
endtask

task automatic test_x0_halt();
    begin_test("x0 and halt");
    poke(data_base, take_bits(32) | 32'h1);
    place(i_format(12'h123, 5'd0, 3'd0, 5'd0, cpu_pkg::op_alu_imm));
    place(load_word(5'd0, data_base[11:0]));
    place(store_word(5'd0, result_base[11:0]));
    place(u_format(20'habcde, 5'd0, cpu_pkg::op_lui));
    place(store_word(5'd0, result_base[11:0] + 12'd4));
    place(i_format(12'h055, 5'd0, 3'd0, 5'd7, cpu_pkg::op_alu_imm));
    place(store_word(5'd7, result_base[11:0] + 12'd8));
    place(32'h0);
    // never reached
    place(store_word(5'd7, result_base[11:0] + 12'd12));
    expect_word(result_base, 32'h0);
    expect_word(result_base + 4, 32'h0);
    expect_word(result_base + 8, 32'h55);
    expect_word(result_base + 12, fill_word(int'(result_base[9:2]) + 3));
    finish_test(20);
endtask

initial
begin
    rst            = 1'b1;
    mem_rdata      = '0;
    lfsr_state     = 32'd3;
    n_writes       = 0;
    n_errors       = 0;
    n_tests        = 0;
    n_failed_tests = 0;
    check_req      = 1'b0;
    check_done     = 1'b0;
    test_name      = "";
    test_reg_alu();
    test_imm_alu();
    test_upper();
    test_branches();
    test_jumps();
    test_x0_halt();
    $display("tests run %0d, tests failing %0d, errors %0d", n_tests, n_failed_tests, n_errors);
    if (n_errors == 0)
        $display("Everything OK");
    else
        $display("Something failed");
    $finish;
end

endmodule

`default_nettype wire

/* vlog.f */
design/cpu_pkg.sv
design/cpu_decode.sv
design/cpu_regfile.sv
design/cpu_alu.sv
design/cpu_control.sv
design/cpu_top.sv
dv/cpu_assert.sv
dv/cpu_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f vlog.f -o cpu_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/cpu_sim > sim.log 2>&1 \
    || echo "simulation exited with an error status" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && exit 1
grep -q "simulation exited with an error status" sim.log && exit 1
exit 0
